// ==== ace_snoop_config.svh ====
`ifndef ACE_SNOOP_CONFIG_SVH
`define ACE_SNOOP_CONFIG_SVH

// Initiators sharing the snooped cache
`define SNP_NUM_INP 4

// Channel widths
`define SNP_ADDR_W 32
`define SNP_DATA_W 32

// Outstanding snoops, bounded by the index queue
`define SNP_IDX_DEPTH 4

// Request buffer toward the cache
`define SNP_AC_DEPTH 2

`endif

// ==== ace_snoop_pkg.sv ====
`default_nettype none

`include "ace_snoop_config.svh"

package ace_snoop_pkg;

    ////////////////////////////////////////////////////////////
    // Initiator index
    ////////////////////////////////////////////////////////////

    typedef logic [$clog2(`SNP_NUM_INP)-1:0] inp_idx_t;

    ////////////////////////////////////////////////////////////
    // ACE snoop channels
    ////////////////////////////////////////////////////////////

    // AC snoop address channel
    typedef struct packed {
        logic [`SNP_ADDR_W-1:0] addr;
        logic [3:0]             snoop;   // Snoop opcode
        logic [2:0]             prot;
    } ac_chan_t;

    // CR snoop response, flag order as on the ACE bus
    typedef struct packed {
        logic was_unique;
        logic is_shared;
        logic pass_dirty;
        logic error;
        logic data_transfer;  // CD burst follows
    } cr_chan_t;

    // CD snoop data beat
    typedef struct packed {
        logic [`SNP_DATA_W-1:0] data;
        logic                   last;
    } cd_chan_t;

endpackage

`default_nettype wire

// ==== snoop_stream_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ace_snoop_config.svh"

module snoop_stream_fifo import ace_snoop_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,

    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);
    // Request buffer stays shallow, index queues bound the outstanding snoops
    localparam int unsigned DEPTH = ($bits(payload_t) == $bits(ac_chan_t)) ?
                                    `SNP_AC_DEPTH : `SNP_IDX_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] used;      // Ring plus output stage
    logic             out_valid;
    payload_t         out_data;

    logic push;
    logic pop;
    logic load_out;
    logic mem_empty;
    logic mem_rd;
    logic mem_wr;
    logic bypass;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign ready_o   = (used != CNT_W'(DEPTH));
    assign push      = valid_i & ready_o;
    assign pop       = out_valid & ready_i;
    assign load_out  = ~out_valid | pop;      // Output stage free next cycle
    assign mem_empty = (rd_ptr == wr_ptr);    // Ring never fills, head sits in output
    assign mem_rd    = load_out & ~mem_empty;
    assign bypass    = load_out & mem_empty & push;
    assign mem_wr    = push & ~bypass;

    assign valid_o = out_valid;
    assign data_o  = out_data;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            used      <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (mem_rd) rd_ptr <= ptr_inc(rd_ptr);
            if (load_out) out_valid <= mem_rd | bypass;
            if (push && !pop) begin
                used <= used + 1'b1;
            end else if (pop && !push) begin
                used <= used - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_wr) mem[wr_ptr] <= data_i;
        if (mem_rd) begin
            out_data <= mem[rd_ptr];
        end else if (bypass) begin
            out_data <= data_i;   // Empty queue, straight to output
        end
    end

endmodule

`default_nettype wire

// ==== snoop_ac_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ace_snoop_config.svh"

module snoop_ac_decode import ace_snoop_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    input  logic     [`SNP_NUM_INP-1:0] inp_ac_valid_i,
    output logic     [`SNP_NUM_INP-1:0] inp_ac_ready_o,
    input  ac_chan_t [`SNP_NUM_INP-1:0] inp_ac_chan_i,

    output logic                         req_valid_o,
    input  logic                         req_ready_i,
    output ac_chan_t                     req_chan_o,

    output logic                         idx_valid_o,
    input  logic                         idx_ready_i,
    output inp_idx_t                     idx_o
);
    localparam int NUM_INP = `SNP_NUM_INP;

    inp_idx_t rr_ptr;     // Highest priority this cycle
    inp_idx_t winner;
    logic     found;
    logic     both_ready;
    logic     accept;

    ////////////////////////////////////////////////////////////
    // Round-robin search
    ////////////////////////////////////////////////////////////

    always_comb begin
        int cand;
        found  = 1'b0;
        winner = rr_ptr;
        for (int i = 0; i < NUM_INP; i++) begin
            cand = (int'(rr_ptr) + i) % NUM_INP;
            if (!found && inp_ac_valid_i[cand]) begin
                found  = 1'b1;
                winner = inp_idx_t'(cand);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Fork into request and index queues
    ////////////////////////////////////////////////////////////

    // Both queues take the request in the same cycle or neither does
    assign both_ready = req_ready_i & idx_ready_i;
    assign accept     = found & both_ready;

    assign req_valid_o = accept;
    assign idx_valid_o = accept;
    assign req_chan_o  = inp_ac_chan_i[winner];
    assign idx_o       = winner;

    always_comb begin
        inp_ac_ready_o         = '0;
        inp_ac_ready_o[winner] = accept;
    end

    // Pointer moves past the winner on each grant
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rr_ptr <= '0;
        end else if (accept) begin
            rr_ptr <= (winner == inp_idx_t'(NUM_INP - 1)) ? '0 : winner + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== snoop_resp_route.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ace_snoop_config.svh"

module snoop_resp_route import ace_snoop_pkg::*; (
    // Head of the issue order queue
    input  logic                         idx_valid_i,
    output logic                         idx_ready_o,
    input  inp_idx_t                     idx_i,

    // CR from the snooped cache
    input  logic                         oup_cr_valid_i,
    output logic                         oup_cr_ready_o,
    input  cr_chan_t                     oup_cr_chan_i,

    // CR toward the initiators
    output logic     [`SNP_NUM_INP-1:0] inp_cr_valids_o,
    input  logic     [`SNP_NUM_INP-1:0] inp_cr_readies_i,
    output cr_chan_t [`SNP_NUM_INP-1:0] inp_cr_chans_o,

    // Pending data index queue
    output logic                         dq_valid_o,
    input  logic                         dq_ready_i,
    output inp_idx_t                     dq_idx_o
);
    logic need_data;
    logic sel_ready;
    logic dq_room;
    logic fire;

    assign need_data = oup_cr_chan_i.data_transfer;
    assign sel_ready = inp_cr_readies_i[idx_i];
    assign dq_room   = ~need_data | dq_ready_i;   // Data queue only matters with data

    ////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////

    assign fire = idx_valid_i & oup_cr_valid_i & sel_ready & dq_room;

    assign oup_cr_ready_o = idx_valid_i & sel_ready & dq_room;
    assign idx_ready_o    = fire;

    // Second branch of the fork, enabled by DataTransfer
    assign dq_valid_o = idx_valid_i & oup_cr_valid_i & need_data & sel_ready;
    assign dq_idx_o   = idx_i;

    ////////////////////////////////////////////////////////////
    // Demux to the issuing initiator
    ////////////////////////////////////////////////////////////

    always_comb begin
        inp_cr_valids_o        = '0;
        inp_cr_valids_o[idx_i] = idx_valid_i & oup_cr_valid_i & dq_room;
    end

    assign inp_cr_chans_o = {`SNP_NUM_INP{oup_cr_chan_i}};  // Valid picks the owner

endmodule

`default_nettype wire

// ==== snoop_data_route.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ace_snoop_config.svh"

module snoop_data_route import ace_snoop_pkg::*; (
    // Initiator still owed a CD burst
    input  logic                         dq_valid_i,
    output logic                         dq_ready_o,
    input  inp_idx_t                     dq_idx_i,

    // CD from the snooped cache
    input  logic                         oup_cd_valid_i,
    output logic                         oup_cd_ready_o,
    input  cd_chan_t                     oup_cd_chan_i,

    // CD toward the initiators
    output logic     [`SNP_NUM_INP-1:0] inp_cd_valids_o,
    input  logic     [`SNP_NUM_INP-1:0] inp_cd_readies_i,
    output cd_chan_t [`SNP_NUM_INP-1:0] inp_cd_chans_o
);
    logic sel_ready;
    logic beat;

    assign sel_ready = inp_cd_readies_i[dq_idx_i];

    // Join of pending index and cache beat
    assign beat = dq_valid_i & oup_cd_valid_i & sel_ready;

    assign oup_cd_ready_o = dq_valid_i & sel_ready;

    // Index retires with the final beat of the burst
    assign dq_ready_o = beat & oup_cd_chan_i.last;

    ////////////////////////////////////////////////////////////
    // Demux to the owning initiator
    ////////////////////////////////////////////////////////////

    always_comb begin
        inp_cd_valids_o           = '0;
        inp_cd_valids_o[dq_idx_i] = dq_valid_i & oup_cd_valid_i;
    end

    assign inp_cd_chans_o = {`SNP_NUM_INP{oup_cd_chan_i}};

endmodule

`default_nettype wire

// ==== ace_snoop_port_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ace_snoop_config.svh"

module ace_snoop_port_top import ace_snoop_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // Initiator side
    input  logic     [`SNP_NUM_INP-1:0] inp_ac_valid_i,
    output logic     [`SNP_NUM_INP-1:0] inp_ac_ready_o,
    input  ac_chan_t [`SNP_NUM_INP-1:0] inp_ac_chan_i,

    output logic     [`SNP_NUM_INP-1:0] inp_cr_valids_o,
    input  logic     [`SNP_NUM_INP-1:0] inp_cr_readies_i,
    output cr_chan_t [`SNP_NUM_INP-1:0] inp_cr_chans_o,

    output logic     [`SNP_NUM_INP-1:0] inp_cd_valids_o,
    input  logic     [`SNP_NUM_INP-1:0] inp_cd_readies_i,
    output cd_chan_t [`SNP_NUM_INP-1:0] inp_cd_chans_o,

    // Snooped cache side
    output logic                         oup_ac_valid_o,
    input  logic                         oup_ac_ready_i,
    output ac_chan_t                     oup_ac_chan_o,

    input  logic                         oup_cr_valid_i,
    output logic                         oup_cr_ready_o,
    input  cr_chan_t                     oup_cr_chan_i,

    input  logic                         oup_cd_valid_i,
    output logic                         oup_cd_ready_o,
    input  cd_chan_t                     oup_cd_chan_i
);
    logic     req_valid;
    logic     req_ready;
    ac_chan_t req_chan;

    logic     idx_in_valid;
    logic     idx_in_ready;
    inp_idx_t idx_in;

    logic     idx_valid;
    logic     idx_ready;
    inp_idx_t idx;

    logic     dq_in_valid;
    logic     dq_in_ready;
    inp_idx_t dq_in_idx;

    logic     dq_valid;
    logic     dq_ready;
    inp_idx_t dq_idx;

    ////////////////////////////////////////////////////////////
    // Request path
    ////////////////////////////////////////////////////////////

    snoop_ac_decode i_ac_decode (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .inp_ac_valid_i (inp_ac_valid_i),
        .inp_ac_ready_o (inp_ac_ready_o),
        .inp_ac_chan_i  (inp_ac_chan_i),
        .req_valid_o    (req_valid),
        .req_ready_i    (req_ready),
        .req_chan_o     (req_chan),
        .idx_valid_o    (idx_in_valid),
        .idx_ready_i    (idx_in_ready),
        .idx_o          (idx_in)
    );

    snoop_stream_fifo #(.payload_t(ac_chan_t)) i_ac_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (req_valid),
        .ready_o (req_ready),
        .data_i  (req_chan),
        .valid_o (oup_ac_valid_o),
        .ready_i (oup_ac_ready_i),
        .data_o  (oup_ac_chan_o)
    );

    snoop_stream_fifo #(.payload_t(inp_idx_t)) i_idx_fifo (   // Issue order
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (idx_in_valid),
        .ready_o (idx_in_ready),
        .data_i  (idx_in),
        .valid_o (idx_valid),
        .ready_i (idx_ready),
        .data_o  (idx)
    );

    ////////////////////////////////////////////////////////////
    // Response and data paths
    ////////////////////////////////////////////////////////////

    snoop_resp_route i_resp_route (
        .idx_valid_i      (idx_valid),
        .idx_ready_o      (idx_ready),
        .idx_i            (idx),
        .oup_cr_valid_i   (oup_cr_valid_i),
        .oup_cr_ready_o   (oup_cr_ready_o),
        .oup_cr_chan_i    (oup_cr_chan_i),
        .inp_cr_valids_o  (inp_cr_valids_o),
        .inp_cr_readies_i (inp_cr_readies_i),
        .inp_cr_chans_o   (inp_cr_chans_o),
        .dq_valid_o       (dq_in_valid),
        .dq_ready_i       (dq_in_ready),
        .dq_idx_o         (dq_in_idx)
    );

    snoop_stream_fifo #(.payload_t(inp_idx_t)) i_dq_fifo (    // Owed CD bursts
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (dq_in_valid),
        .ready_o (dq_in_ready),
        .data_i  (dq_in_idx),
        .valid_o (dq_valid),
        .ready_i (dq_ready),
        .data_o  (dq_idx)
    );

    snoop_data_route i_data_route (
        .dq_valid_i       (dq_valid),
        .dq_ready_o       (dq_ready),
        .dq_idx_i         (dq_idx),
        .oup_cd_valid_i   (oup_cd_valid_i),
        .oup_cd_ready_o   (oup_cd_ready_o),
        .oup_cd_chan_i    (oup_cd_chan_i),
        .inp_cd_valids_o  (inp_cd_valids_o),
        .inp_cd_readies_i (inp_cd_readies_i),
        .inp_cd_chans_o   (inp_cd_chans_o)
    );

endmodule

`default_nettype wire

// ==== tb_ace_snoop_port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ace_snoop_config.svh"

module tb_ace_snoop_port import ace_snoop_pkg::*; ();
    localparam int N       = `SNP_NUM_INP;
    localparam int MAX_REC = 64;

    logic             clk_i;
    logic             rst_n_i;
    logic     [N-1:0] inp_ac_valid_i;
    logic     [N-1:0] inp_ac_ready_o;
    ac_chan_t [N-1:0] inp_ac_chan_i;
    logic     [N-1:0] inp_cr_valids_o;
    logic     [N-1:0] inp_cr_readies_i;
    cr_chan_t [N-1:0] inp_cr_chans_o;
    logic     [N-1:0] inp_cd_valids_o;
    logic     [N-1:0] inp_cd_readies_i;
    cd_chan_t [N-1:0] inp_cd_chans_o;
    logic             oup_ac_valid_o;
    logic             oup_ac_ready_i;
    ac_chan_t         oup_ac_chan_o;
    logic             oup_cr_valid_i;
    logic             oup_cr_ready_o;
    cr_chan_t         oup_cr_chan_i;
    logic             oup_cd_valid_i;
    logic             oup_cd_ready_o;
    cd_chan_t         oup_cd_chan_i;

    // Trace records
    int          rec_test  [MAX_REC];
    int          rec_inp   [MAX_REC];
    ac_chan_t    rec_ac    [MAX_REC];
    cr_chan_t    rec_cr    [MAX_REC];
    int          rec_beats [MAX_REC];
    logic [31:0] rec_data  [MAX_REC][4];
    bit          issued    [MAX_REC];
    int          num_rec;
    int          total_beats;
    int          test_list[$];
    int          test_size[$];

    // Scoreboards, per initiator in request order
    int ac_exp_q[$];
    int cache_q[$];
    int cr_exp[N][MAX_REC];
    int cr_rd[N];
    int cr_wr[N];
    int cd_exp[N][MAX_REC];
    int cd_rd[N];
    int cd_wr[N];
    int cd_beat[N];
    int cur_rec[N];

    int cur_test;
    int rr_ptr;        // Expected grant pointer
    int cache_id;
    int cache_beat;
    bit cache_busy;
    int done_count;
    int err_count;
    int check_count;
    int limit_cycles;

    ace_snoop_port_top UUT (.*);

    function automatic int next_record(input int k);
        for (int i = 0; i < num_rec; i++) begin
            if (!issued[i] && rec_test[i] == cur_test && rec_inp[i] == k)
                return i;
        end
        return -1;
    endfunction

    // First requester at or after the pointer
    function automatic int predict_winner(input logic [N-1:0] valids, input int ptr);
        int c;
        for (int i = 0; i < N; i++) begin
            c = (ptr + i) % N;
            if (valids[c])
                return c;
        end
        return -1;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_unexpected(input string what);
        err_count++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic load_trace(output bit ok);
        int          fd;
        int          n;
        int          tt;
        int          ii;
        int          bb;
        int          last_test;
        logic [31:0] a;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] d3;
        logic [3:0]  sn;
        logic [2:0]  pr;
        logic [4:0]  cr;
        string       line;
        ok = 1'b0;
        last_test = -1;
        fd = $fopen("snoop_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0)
                    n = $sscanf(line, "%d %d %h %h %h %h %d %h %h %h %h",
                                tt, ii, a, sn, pr, cr, bb, d0, d1, d2, d3);
                if (n == 11) begin   // Comment and blank lines fall through
                    rec_test[num_rec]  = tt;
                    rec_inp[num_rec]   = ii;
                    rec_ac[num_rec]    = '{addr: a, snoop: sn, prot: pr};
                    rec_cr[num_rec]    = cr;
                    rec_beats[num_rec] = bb;
                    rec_data[num_rec]  = '{d0, d1, d2, d3};
                    total_beats += 1 + bb;
                    if (tt != last_test) begin
                        test_list.push_back(tt);
                        test_size.push_back(0);
                        last_test = tt;
                    end
                    test_size[test_size.size() - 1]++;
                    num_rec++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_i);
        $display("Timeout after %0d cycles with snoops still outstanding", limit_cycles);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Initiators, cache model and monitors
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : model
        int id;
        int win;
        int done_now;
        bit last_exp;
        if (rst_n_i) begin
            done_now = 0;
            oup_ac_ready_i <= 1'b1;
            if (oup_ac_valid_o && oup_ac_ready_i) begin
                if (ac_exp_q.size() == 0) begin
                    report_unexpected("AC request at the cache that no initiator issued");
                end else begin
                    id = ac_exp_q.pop_front();
                    check_equal(64'(oup_ac_chan_o), 64'(rec_ac[id]),
                                $sformatf("AC at cache, record %0d", id));
                    cache_q.push_back(id);
                end
            end
            for (int k = 0; k < N; k++) begin
                if (inp_cd_valids_o[k] && inp_cd_readies_i[k]) begin
                    if (cd_rd[k] == cd_wr[k]) begin
                        report_unexpected($sformatf("CD beat at initiator %0d, no data owed", k));
                    end else begin
                        id = cd_exp[k][cd_rd[k]];
                        last_exp = (cd_beat[k] == rec_beats[id] - 1);
                        check_equal(64'(inp_cd_chans_o[k].data), 64'(rec_data[id][cd_beat[k]]),
                                    $sformatf("CD data, record %0d", id));
                        check_equal(64'(inp_cd_chans_o[k].last), 64'(last_exp),
                                    $sformatf("CD last, record %0d", id));
                        cd_beat[k]++;
                        if (last_exp) begin
                            cd_rd[k]++;
                            cd_beat[k] = 0;
                            done_now++;
                        end
                    end
                end
                if (inp_cr_valids_o[k] && inp_cr_readies_i[k]) begin
                    if (cr_rd[k] == cr_wr[k]) begin
                        report_unexpected($sformatf("CR at initiator %0d, no snoop pending", k));
                    end else begin
                        id = cr_exp[k][cr_rd[k]];
                        cr_rd[k]++;
                        check_equal(64'(inp_cr_chans_o[k]), 64'(rec_cr[id]),
                                    $sformatf("CR flags, record %0d", id));
                        if (rec_cr[id].data_transfer) begin
                            cd_exp[k][cd_wr[k]] = id;
                            cd_wr[k]++;
                        end else begin
                            done_now++;
                        end
                    end
                end
                inp_cr_readies_i[k] <= ($urandom % 4) != 0;  // Random stalls
                inp_cd_readies_i[k] <= ($urandom % 4) != 0;
            end
            if (|(inp_ac_valid_i & inp_ac_ready_o)) begin
                win = predict_winner(inp_ac_valid_i, rr_ptr);
                check_equal(64'(inp_ac_ready_o), 64'(1) << win, "AC grant");
                for (int k = 0; k < N; k++) begin
                    if (inp_ac_valid_i[k] && inp_ac_ready_o[k]) begin
                        ac_exp_q.push_back(cur_rec[k]);
                        cr_exp[k][cr_wr[k]] = cur_rec[k];
                        cr_wr[k]++;
                        rr_ptr = (k + 1) % N;
                    end
                end
            end
            for (int k = 0; k < N; k++) begin
                if (!inp_ac_valid_i[k] || inp_ac_ready_o[k]) begin
                    id = next_record(k);
                    if (id >= 0) begin
                        issued[id] = 1'b1;
                        cur_rec[k] = id;
                        inp_ac_valid_i[k] <= 1'b1;
                        inp_ac_chan_i[k]  <= rec_ac[id];
                    end else begin
                        inp_ac_valid_i[k] <= 1'b0;
                    end
                end
            end

            // Cache answers strictly in arrival order
            if (oup_cr_valid_i && oup_cr_ready_o) begin
                oup_cr_valid_i <= 1'b0;
                cache_beat = 0;
                if (rec_cr[cache_id].data_transfer) begin
                    oup_cd_valid_i <= 1'b1;
                    oup_cd_chan_i  <= '{data: rec_data[cache_id][0],
                                        last: (rec_beats[cache_id] == 1)};
                end else begin
                    cache_busy = 1'b0;
                end
            end
            if (oup_cd_valid_i && oup_cd_ready_o) begin
                cache_beat++;
                if (cache_beat == rec_beats[cache_id]) begin
                    oup_cd_valid_i <= 1'b0;
                    cache_busy = 1'b0;
                end else begin
                    oup_cd_chan_i <= '{data: rec_data[cache_id][cache_beat],
                                       last: (cache_beat == rec_beats[cache_id] - 1)};
                end
            end
            if (!cache_busy && cache_q.size() > 0) begin
                cache_id = cache_q.pop_front();
                cache_busy = 1'b1;
                oup_cr_valid_i <= 1'b1;
                oup_cr_chan_i  <= rec_cr[cache_id];
            end
            done_count <= done_count + done_now;
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        bit ok;
        int goal;
        int errs_before;
        int tests_failed;
        rst_n_i          <= 1'b0;
        inp_ac_valid_i   <= '0;
        inp_ac_chan_i    <= '0;
        inp_cr_readies_i <= '0;
        inp_cd_readies_i <= '0;
        oup_ac_ready_i   <= 1'b0;
        oup_cr_valid_i   <= 1'b0;
        oup_cr_chan_i    <= '0;
        oup_cd_valid_i   <= 1'b0;
        oup_cd_chan_i    <= '0;
        void'($urandom(32'h6ec3ba71));
        tests_failed = 0;
        load_trace(ok);
        if (!ok) begin
            $display("Cannot open the trace file snoop_trace.txt");
            $display("Result: FAILED");
            $finish;
        end else begin
            limit_cycles = (total_beats + 50) * 8;
            repeat (3) @(posedge clk_i);
            rst_n_i <= 1'b1;
            @(posedge clk_i);
            check_equal(64'(inp_ac_ready_o), 64'(0), "AC readies after reset");
            check_equal(64'(inp_cr_valids_o), 64'(0), "CR valids after reset");
            check_equal(64'(inp_cd_valids_o), 64'(0), "CD valids after reset");
            check_equal(64'({oup_ac_valid_o, oup_cr_ready_o, oup_cd_ready_o}), 64'(0),
                        "Cache side handshakes after reset");
            if (err_count != 0)
                tests_failed++;
            $display("Test 1: reset state, %0d errors", err_count);
            foreach (test_list[j]) begin
                goal = done_count + test_size[j];
                errs_before = err_count;
                cur_test <= test_list[j];
                while (done_count < goal) @(posedge clk_i);
                @(posedge clk_i);
                if (err_count != errs_before)
                    tests_failed++;
                $display("Test %0d: %0d snoops done, %0d errors",
                         test_list[j], test_size[j], err_count - errs_before);
            end
            $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                     test_list.size() + 1, tests_failed, check_count, err_count);
            if (err_count == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== snoop_trace.txt ====
# test initiator addr snoop prot cr_flags beats data0 data1 data2 data3 (numbers in hex but test and beats)
# cr_flags bits: 4 WasUnique, 3 IsShared, 2 PassDirty, 1 Error, 0 DataTransfer
2 1 80001040 1 2 08 0 0 0 0 0
2 3 80002080 7 0 01 1 cafe0001 0 0 0
3 0 00010000 0 0 00 0 0 0 0 0
3 1 00010040 1 1 08 0 0 0 0 0
3 2 00010080 7 2 10 0 0 0 0 0
3 3 000100c0 b 3 18 0 0 0 0 0
4 2 20000000 1 0 08 0 0 0 0 0
4 2 20000040 9 0 02 0 0 0 0 0
4 0 20000080 7 0 1c 0 0 0 0 0
4 3 200000c0 d 4 04 0 0 0 0 0
4 1 20000100 1 0 18 0 0 0 0 0
4 0 20000140 8 0 00 0 0 0 0 0
5 0 40000000 1 2 01 1 11110000 0 0 0
5 1 40000040 7 2 05 2 22220000 22220001 0 0
5 2 40000080 9 2 0d 3 33330000 33330001 33330002 0
5 3 400000c0 1 2 19 4 44440000 44440001 44440002 44440003
5 0 40000100 e 2 15 2 55550000 55550001 0 0
5 2 40000140 7 2 01 1 66660000 0 0 0
6 1 60000000 1 0 09 2 a0000000 a0000001 0 0
6 1 60000040 7 0 00 0 0 0 0 0
6 3 60000080 9 1 05 4 b0000000 b0000001 b0000002 b0000003
6 0 600000c0 1 0 08 0 0 0 0 0
6 2 60000100 d 3 01 1 c0000000 0 0 0
6 0 60000140 7 0 19 3 d0000000 d0000001 d0000002 0
6 3 60000180 1 0 10 0 0 0 0 0
6 2 600001c0 9 0 0d 2 e0000000 e0000001 0 0
6 1 60000200 b 5 02 0 0 0 0 0
6 0 60000240 1 0 01 4 f0000000 f0000001 f0000002 f0000003

// ==== src.f ====
+incdir+.
ace_snoop_pkg.sv
snoop_stream_fifo.sv
snoop_ac_decode.sv
snoop_resp_route.sv
snoop_data_route.sv
ace_snoop_port_top.sv
tb_ace_snoop_port.sv

// ==== Makefile ====
TOP             ?= tb_ace_snoop_port
SIM_DIR         ?= obj_dir
FILE_LIST       ?= src.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing
PASS_MSG        ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(SIM_DIR)

# Output is shown and then searched for the pass line
run: compile
	@out="$$(./$(SIM_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(SIM_DIR)
